// ==== verification/queue_ctrl_tests.txt ====
# op name, then hex fields: W addr full_slots part_slots base | R addr quarter line_bits | N addr
# T queue dsc pkt | L queue tail_wr dsc pkt, H queue dsc_head pkt_head, each + dh dt da ph pt pa
# host writes to the table slots and read back
T t_q3_tails 3 0a11 0b22
W w_q3_slots 3000 00ff 0000 30000000
R r_q3_low 3000 0 30000003300000023000000100000a11
R r_q3_high 3000 1 30000007300000063000000500000b22
L l_q3 3 0 0 0 0001 0a11 3000000330000002 0005 0b22 3000000730000006
# partial byte enables and the c2f registers
W w_q3_partial 3000 0f00 000e 40000000
R r_q3_kept 3000 0 30000003300000023000000100000a11
R r_c2f 3000 2 4000000b4000000a0000000040000008
R r_pad 3000 3 00000000000000000000000000000000
# read above the register region, then a normal read
N n_above 13000
R r_after_above 3000 1 30000007300000063000000500000b22
# tail write back, then a lookup
W w_q5_slots 5000 00ee 0000 50a00000
T t_q5_tails 5 1234 5678
L l_q5 5 0 0 0 0001 1234 50a0000350a00002 0005 5678 50a0000750a00006
# lookup with a same-queue tail write, the ram write is lost
L l_q5_tail_byp 5 1 2345 6789 0001 2345 50a0000350a00002 0005 6789 50a0000750a00006
L l_q5_tail_lost 5 0 0 0 0001 1234 50a0000350a00002 0005 5678 50a0000750a00006
# host head write in the lookup cycle
H h_q5_head_byp 5 0abc 0def 0abc 1234 50a0000350a00002 0def 5678 50a0000750a00006
L l_q5_heads 5 0 0 0 0abc 1234 50a0000350a00002 0def 5678 50a0000750a00006
R r_q5_low 5000 0 50a0000350a0000200000abc00001234
R r_q5_high 5000 1 50a0000750a0000600000def00005678

// ==== tb.f ====
+incdir+include
rtl/queue_ctrl_pkg.sv
rtl/q_table_ram.sv
rtl/pcie_reg_port.sv
rtl/queue_lookup.sv
rtl/queue_ctrl_top.sv
verification/queue_ctrl_tb.sv

// ==== Bender.yml ====
package:
  name: queue_ctrl

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/queue_ctrl_pkg.sv
      - rtl/q_table_ram.sv
      - rtl/pcie_reg_port.sv
      - rtl/queue_lookup.sv
      - rtl/queue_ctrl_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verification/queue_ctrl_tb.sv

// ==== verification/queue_ctrl_tb.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "queue_ctrl_macros.svh"

module queue_ctrl_tb;

localparam int SLOT_W        = `REG_SLOT_WIDTH;
localparam int NB_SLOTS      = `REG_LINE_WIDTH / `REG_SLOT_WIDTH;
localparam int SLOT_BYTES    = `REG_BYTEEN_WIDTH / NB_SLOTS;
localparam int DSC_HEAD_SLOT = 1;
localparam int PKT_HEAD_SLOT = 5;
localparam int WAIT_LIMIT    = 40;

logic                          pcie_clk;
logic                          pcie_reset_n;
logic [`PCIE_ADDR_WIDTH-1:0]   pcie_address_0;
logic                          pcie_write_0;
logic                          pcie_read_0;
logic [`REG_LINE_WIDTH-1:0]    pcie_writedata_0;
logic [`REG_BYTEEN_WIDTH-1:0]  pcie_byteenable_0;
logic [`REG_LINE_WIDTH-1:0]    pcie_readdata_0;
logic                          pcie_readdatavalid_0;
logic [`QUEUE_IDX_WIDTH-1:0]   rd_queue;
logic                          queue_rd_en;
logic [`QUEUE_IDX_WIDTH-1:0]   wr_queue;
logic                          tail_wr_en;
logic [`RB_AWIDTH-1:0]         new_dsc_tail;
logic [`RB_AWIDTH-1:0]         new_pkt_tail;
logic                          queue_ready;
logic [`RB_AWIDTH-1:0]         dsc_head;
logic [`RB_AWIDTH-1:0]         dsc_tail;
logic [63:0]                   dsc_buf_addr;
logic [`RB_AWIDTH-1:0]         pkt_head;
logic [`RB_AWIDTH-1:0]         pkt_tail;
logic [63:0]                   pkt_buf_addr;

// fields of the current test line
string                         line;
string                         op;
string                         name;
logic [`PCIE_ADDR_WIDTH-1:0]   v_addr;
logic [15:0]                   v_full;
logic [15:0]                   v_part;
logic [31:0]                   v_base;
logic [1:0]                    v_quarter;
logic [127:0]                  v_line;
logic [`QUEUE_IDX_WIDTH-1:0]   v_queue;
logic                          v_flag;
logic [`RB_AWIDTH-1:0]         v_dsc;
logic [`RB_AWIDTH-1:0]         v_pkt;
logic [`RB_AWIDTH-1:0]         e_dh;
logic [`RB_AWIDTH-1:0]         e_dt;
logic [63:0]                   e_da;
logic [`RB_AWIDTH-1:0]         e_ph;
logic [`RB_AWIDTH-1:0]         e_pt;
logic [63:0]                   e_pa;

int fd;
int n_tests;
int rand_init;
int cycle_count = 0;
int cycle_limit = 100;

queue_ctrl_top dut0 (
    .pcie_clk             (pcie_clk),
    .pcie_reset_n         (pcie_reset_n),
    .pcie_address_0       (pcie_address_0),
    .pcie_write_0         (pcie_write_0),
    .pcie_read_0          (pcie_read_0),
    .pcie_writedata_0     (pcie_writedata_0),
    .pcie_byteenable_0    (pcie_byteenable_0),
    .pcie_readdata_0      (pcie_readdata_0),
    .pcie_readdatavalid_0 (pcie_readdatavalid_0),
    .rd_queue             (rd_queue),
    .queue_rd_en          (queue_rd_en),
    .wr_queue             (wr_queue),
    .tail_wr_en           (tail_wr_en),
    .new_dsc_tail         (new_dsc_tail),
    .new_pkt_tail         (new_pkt_tail),
    .queue_ready          (queue_ready),
    .dsc_head             (dsc_head),
    .dsc_tail             (dsc_tail),
    .dsc_buf_addr         (dsc_buf_addr),
    .pkt_head             (pkt_head),
    .pkt_tail             (pkt_tail),
    .pkt_buf_addr         (pkt_buf_addr)
);

initial begin
    pcie_clk = 1'b0;
end

always #4 pcie_clk = ~pcie_clk;

always @(posedge pcie_clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
        abort_run($sformatf("timeout, the run went past %0d cycles", cycle_limit));
    end
end

//////////////////////////////
// helpers
//////////////////////////////

task automatic abort_run(input string what);
    $display("%s", what);
    $display("TESTS FAILED");
    $fatal(1, "run stopped");
endtask

task automatic compare_value(input string label, input logic [127:0] expected,
                             input logic [127:0] actual);
    if (actual !== expected) begin
        $display("[ERROR] %s: expected %0h, actual %0h", label, expected, actual);
        $display("TESTS FAILED");
        $fatal(1, "value mismatch");
    end
endtask

function automatic bit is_test_line(input string s);
    return s.len() > 1 && s.getc(0) != "#";
endfunction

task automatic require_fields(input int got, input int want);
    if (got != want) begin
        abort_run({"malformed line in the test file for ", name});
    end
endtask

// at least one idle cycle so a lookup never meets the previous host write
task automatic pause_random();
    repeat (1 + $urandom % 4) @(negedge pcie_clk);
endtask

//////////////////////////////
// operations, entered at a falling edge
//////////////////////////////

task automatic apply_write(input logic [`PCIE_ADDR_WIDTH-1:0] addr, input logic [15:0] full,
                           input logic [15:0] part, input logic [31:0] base);
    int k;
    pcie_address_0 = addr;
    for (k = 0; k < NB_SLOTS; k++) begin
        pcie_writedata_0[k*SLOT_W +: SLOT_W] = base + k;
        // a partial slot misses its top byte
        if (full[k]) begin
            pcie_byteenable_0[k*SLOT_BYTES +: SLOT_BYTES] = 4'hf;
        end else if (part[k]) begin
            pcie_byteenable_0[k*SLOT_BYTES +: SLOT_BYTES] = 4'h7;
        end else begin
            pcie_byteenable_0[k*SLOT_BYTES +: SLOT_BYTES] = 4'h0;
        end
    end
    pcie_write_0 = 1'b1;
    @(negedge pcie_clk);
    pcie_write_0      = 1'b0;
    pcie_byteenable_0 = '0;
endtask

task automatic write_heads(input logic [`QUEUE_IDX_WIDTH-1:0] queue,
                           input logic [`RB_AWIDTH-1:0] dh, input logic [`RB_AWIDTH-1:0] ph);
    pcie_address_0 = '0;
    pcie_address_0[`PAGE_IDX_LSB +: `QUEUE_IDX_WIDTH] = queue;
    pcie_writedata_0  = '0;
    pcie_writedata_0[DSC_HEAD_SLOT*SLOT_W +: `RB_AWIDTH] = dh;
    pcie_writedata_0[PKT_HEAD_SLOT*SLOT_W +: `RB_AWIDTH] = ph;
    pcie_byteenable_0 = '0;
    pcie_byteenable_0[DSC_HEAD_SLOT*SLOT_BYTES +: SLOT_BYTES] = 4'hf;
    pcie_byteenable_0[PKT_HEAD_SLOT*SLOT_BYTES +: SLOT_BYTES] = 4'hf;
    pcie_write_0 = 1'b1;
    @(negedge pcie_clk);
    pcie_write_0      = 1'b0;
    pcie_byteenable_0 = '0;
endtask

task automatic read_and_check(input string label, input logic [`PCIE_ADDR_WIDTH-1:0] addr,
                              input int quarter, input logic [127:0] expected);
    int waited;
    pcie_address_0 = addr;
    pcie_read_0    = 1'b1;
    @(negedge pcie_clk);
    pcie_read_0 = 1'b0;
    waited      = 0;
    while (!pcie_readdatavalid_0 && waited < WAIT_LIMIT) begin
        @(negedge pcie_clk);
        waited++;
    end
    if (!pcie_readdatavalid_0) begin
        abort_run({label, ": no read data valid within 40 cycles"});
    end
    compare_value(label, expected, pcie_readdata_0[128*quarter +: 128]);
endtask

task automatic expect_no_read(input string label, input logic [`PCIE_ADDR_WIDTH-1:0] addr);
    pcie_address_0 = addr;
    pcie_read_0    = 1'b1;
    @(negedge pcie_clk);
    pcie_read_0 = 1'b0;
    repeat (WAIT_LIMIT) begin
        @(negedge pcie_clk);
        if (pcie_readdatavalid_0) begin
            abort_run({label, ": a read outside the register region returned data"});
        end
    end
endtask

task automatic write_tails(input logic [`QUEUE_IDX_WIDTH-1:0] queue,
                           input logic [`RB_AWIDTH-1:0] dsc, input logic [`RB_AWIDTH-1:0] pkt);
    wr_queue     = queue;
    new_dsc_tail = dsc;
    new_pkt_tail = pkt;
    tail_wr_en   = 1'b1;
    @(negedge pcie_clk);
    tail_wr_en = 1'b0;
endtask

// expected outputs come from e_dh .. e_pa
task automatic run_lookup(input string label, input logic [`QUEUE_IDX_WIDTH-1:0] queue,
                          input logic with_tail, input logic [`RB_AWIDTH-1:0] dsc,
                          input logic [`RB_AWIDTH-1:0] pkt);
    int waited;
    rd_queue    = queue;
    queue_rd_en = 1'b1;
    if (with_tail) begin
        wr_queue     = queue;
        new_dsc_tail = dsc;
        new_pkt_tail = pkt;
        tail_wr_en   = 1'b1;
    end
    @(negedge pcie_clk);
    queue_rd_en = 1'b0;
    tail_wr_en  = 1'b0;
    waited      = 1;
    while (!queue_ready && waited < WAIT_LIMIT) begin
        @(negedge pcie_clk);
        waited++;
    end
    if (!queue_ready) begin
        abort_run({label, ": queue_ready never came after the lookup"});
    end
    compare_value({label, " latency"}, 2, waited);
    compare_value({label, " dsc_head"}, e_dh, dsc_head);
    compare_value({label, " dsc_tail"}, e_dt, dsc_tail);
    compare_value({label, " dsc_buf_addr"}, e_da, dsc_buf_addr);
    compare_value({label, " pkt_head"}, e_ph, pkt_head);
    compare_value({label, " pkt_tail"}, e_pt, pkt_tail);
    compare_value({label, " pkt_buf_addr"}, e_pa, pkt_buf_addr);
endtask

task automatic run_test_line(input string text);
    int code;
    code = $sscanf(text, "%s %s", op, name);
    if (op == "W") begin
        code = $sscanf(text, "%s %s %h %h %h %h", op, name, v_addr, v_full, v_part, v_base);
        require_fields(code, 6);
        apply_write(v_addr, v_full, v_part, v_base);
    end else if (op == "R") begin
        code = $sscanf(text, "%s %s %h %h %h", op, name, v_addr, v_quarter, v_line);
        require_fields(code, 5);
        read_and_check(name, v_addr, v_quarter, v_line);
    end else if (op == "N") begin
        code = $sscanf(text, "%s %s %h", op, name, v_addr);
        require_fields(code, 3);
        expect_no_read(name, v_addr);
    end else if (op == "T") begin
        code = $sscanf(text, "%s %s %h %h %h", op, name, v_queue, v_dsc, v_pkt);
        require_fields(code, 5);
        write_tails(v_queue, v_dsc, v_pkt);
    end else if (op == "L") begin
        code = $sscanf(text, "%s %s %h %h %h %h %h %h %h %h %h %h", op, name, v_queue,
                       v_flag, v_dsc, v_pkt, e_dh, e_dt, e_da, e_ph, e_pt, e_pa);
        require_fields(code, 12);
        run_lookup(name, v_queue, v_flag, v_dsc, v_pkt);
    end else if (op == "H") begin
        code = $sscanf(text, "%s %s %h %h %h %h %h %h %h %h %h", op, name, v_queue,
                       v_dsc, v_pkt, e_dh, e_dt, e_da, e_ph, e_pt, e_pa);
        require_fields(code, 11);
        // lookup lands in the cycle port b writes the heads
        write_heads(v_queue, v_dsc, v_pkt);
        run_lookup(name, v_queue, 1'b0, '0, '0);
    end else begin
        abort_run({"unknown operation ", op, " in the test file"});
    end
endtask

//////////////////////////////
// main sequence
//////////////////////////////

initial begin
    pcie_reset_n      = 1'b0;
    pcie_address_0    = '0;
    pcie_write_0      = 1'b0;
    pcie_read_0       = 1'b0;
    pcie_writedata_0  = '0;
    pcie_byteenable_0 = '0;
    rd_queue          = '0;
    queue_rd_en       = 1'b0;
    wr_queue          = '0;
    tail_wr_en        = 1'b0;
    new_dsc_tail      = '0;
    new_pkt_tail      = '0;
    rand_init         = $urandom(32'h7549);
    n_tests           = 0;

    // first pass sizes the cycle budget
    fd = $fopen("verification/queue_ctrl_tests.txt", "r");
    if (fd == 0) begin
        abort_run("cannot open verification/queue_ctrl_tests.txt");
    end
    while ($fgets(line, fd) > 0) begin
        if (is_test_line(line)) begin
            n_tests++;
        end
    end
    $fclose(fd);
    cycle_limit = WAIT_LIMIT * n_tests + 100;

    repeat (3) @(negedge pcie_clk);
    pcie_reset_n = 1'b1;

    fd = $fopen("verification/queue_ctrl_tests.txt", "r");
    while ($fgets(line, fd) > 0) begin
        if (is_test_line(line)) begin
            pause_random();
            run_test_line(line);
        end
    end
    $fclose(fd);

    if (n_tests > 0) begin
        $display("TESTS PASSED");
        $finish;
    end else begin
        abort_run("the test file holds no tests");
    end
end

endmodule

`default_nettype wire

// ==== rtl/queue_ctrl_top.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "queue_ctrl_macros.svh"

module queue_ctrl_top (
    input  logic                         pcie_clk,
    input  logic                         pcie_reset_n,
    input  logic [`PCIE_ADDR_WIDTH-1:0]  pcie_address_0,
    input  logic                         pcie_write_0,
    input  logic                         pcie_read_0,
    input  logic [`REG_LINE_WIDTH-1:0]   pcie_writedata_0,
    input  logic [`REG_BYTEEN_WIDTH-1:0] pcie_byteenable_0,
    output logic [`REG_LINE_WIDTH-1:0]   pcie_readdata_0,
    output logic                         pcie_readdatavalid_0,
    input  logic [`QUEUE_IDX_WIDTH-1:0]  rd_queue,
    input  logic                         queue_rd_en,
    input  logic [`QUEUE_IDX_WIDTH-1:0]  wr_queue,
    input  logic                         tail_wr_en,
    input  logic [`RB_AWIDTH-1:0]        new_dsc_tail,
    input  logic [`RB_AWIDTH-1:0]        new_pkt_tail,
    output logic                         queue_ready,
    output logic [`RB_AWIDTH-1:0]        dsc_head,
    output logic [`RB_AWIDTH-1:0]        dsc_tail,
    output logic [63:0]                  dsc_buf_addr,
    output logic [`RB_AWIDTH-1:0]        pkt_head,
    output logic [`RB_AWIDTH-1:0]        pkt_tail,
    output logic [63:0]                  pkt_buf_addr
);

localparam int SLOT_W = `REG_SLOT_WIDTH;

logic [`NB_TABLES-1:0]        b_wr_en;
logic [`NB_TABLES-1:0]        b_wr_en_ram;
logic                         b_rd_en;
logic                         b_rd_en_ram;
logic [`QUEUE_IDX_WIDTH-1:0]  b_addr;
logic [`NB_TABLES*SLOT_W-1:0] b_wr_data;
logic [`NB_TABLES*SLOT_W-1:0] b_rd_data;
queue_ctrl_pkg::port_b_op_e   b_op;
logic [1:0]                   b_head_wr_en;
logic [2*`RB_AWIDTH-1:0]      b_head_wr_data;

logic [`QUEUE_IDX_WIDTH-1:0]  a_addr;
logic [`NB_TABLES-1:0]        a_rd_en;
logic                         a_tail_wr_en;
logic [2*`RB_AWIDTH-1:0]      a_tail_wr_data;
logic [`NB_TABLES*SLOT_W-1:0] a_rd_data;

pcie_reg_port u_reg_port (
    .pcie_clk             (pcie_clk),
    .pcie_reset_n         (pcie_reset_n),
    .pcie_address_0       (pcie_address_0),
    .pcie_write_0         (pcie_write_0),
    .pcie_read_0          (pcie_read_0),
    .pcie_writedata_0     (pcie_writedata_0),
    .pcie_byteenable_0    (pcie_byteenable_0),
    .b_wr_en              (b_wr_en),
    .b_rd_en              (b_rd_en),
    .b_addr               (b_addr),
    .b_wr_data            (b_wr_data),
    .b_rd_data            (b_rd_data),
    .pcie_readdata_0      (pcie_readdata_0),
    .pcie_readdatavalid_0 (pcie_readdatavalid_0)
);

// port b enables, a write never shares the cycle with a read
always_comb begin
    if (|b_wr_en) begin
        b_op = queue_ctrl_pkg::port_b_write;
    end else if (b_rd_en) begin
        b_op = queue_ctrl_pkg::port_b_read;
    end else begin
        b_op = queue_ctrl_pkg::port_b_idle;
    end
end

assign b_wr_en_ram = (b_op == queue_ctrl_pkg::port_b_write) ? b_wr_en : '0;
assign b_rd_en_ram = b_op == queue_ctrl_pkg::port_b_read;

// head writes seen by the lookup bypass
assign b_head_wr_en = {b_wr_en_ram[queue_ctrl_pkg::pkt_heads],
                       b_wr_en_ram[queue_ctrl_pkg::dsc_heads]};
assign b_head_wr_data = {b_wr_data[queue_ctrl_pkg::pkt_heads*SLOT_W +: `RB_AWIDTH],
                         b_wr_data[queue_ctrl_pkg::dsc_heads*SLOT_W +: `RB_AWIDTH]};

queue_lookup u_lookup (
    .pcie_clk       (pcie_clk),
    .pcie_reset_n   (pcie_reset_n),
    .rd_queue       (rd_queue),
    .queue_rd_en    (queue_rd_en),
    .wr_queue       (wr_queue),
    .tail_wr_en     (tail_wr_en),
    .new_dsc_tail   (new_dsc_tail),
    .new_pkt_tail   (new_pkt_tail),
    .b_head_wr_en   (b_head_wr_en),
    .b_addr         (b_addr),
    .b_head_wr_data (b_head_wr_data),
    .a_addr         (a_addr),
    .a_rd_en        (a_rd_en),
    .a_tail_wr_en   (a_tail_wr_en),
    .a_tail_wr_data (a_tail_wr_data),
    .a_rd_data      (a_rd_data),
    .queue_ready    (queue_ready),
    .dsc_head       (dsc_head),
    .dsc_tail       (dsc_tail),
    .dsc_buf_addr   (dsc_buf_addr),
    .pkt_head       (pkt_head),
    .pkt_tail       (pkt_tail),
    .pkt_buf_addr   (pkt_buf_addr)
);

//////////////////////////////
// queue tables
//////////////////////////////

for (genvar t = 0; t < `NB_TABLES; t++) begin : g_table
    localparam queue_ctrl_pkg::q_table_e TBL = queue_ctrl_pkg::q_table_e'(t);
    localparam bit IS_TAIL = TBL == queue_ctrl_pkg::dsc_tails
        || TBL == queue_ctrl_pkg::pkt_tails;
    localparam int DWIDTH   = IS_TAIL ? `RB_AWIDTH : SLOT_W;
    localparam int TAIL_LSB = (TBL == queue_ctrl_pkg::pkt_tails) ? `RB_AWIDTH : 0;

    logic [DWIDTH-1:0] data_a;
    logic [DWIDTH-1:0] q_a;
    logic [DWIDTH-1:0] q_b;

    // only the tail tables take writes on port a
    if (IS_TAIL) begin : g_tail
        assign data_a = a_tail_wr_data[TAIL_LSB +: `RB_AWIDTH];
    end else begin : g_word
        assign data_a = '0;
    end

    q_table_ram #(
        .AWIDTH (`QUEUE_IDX_WIDTH),
        .DWIDTH (DWIDTH),
        .DEPTH  (`RAM_DEPTH)
    ) u_ram (
        .pcie_clk  (pcie_clk),
        .address_a (a_addr),
        .address_b (b_addr),
        .data_a    (data_a),
        .data_b    (b_wr_data[t*SLOT_W +: DWIDTH]),
        .rden_a    (a_rd_en[t]),
        .rden_b    (b_rd_en_ram),
        .wren_a    (IS_TAIL && a_tail_wr_en),
        .wren_b    (b_wr_en_ram[t]),
        .q_a       (q_a),
        .q_b       (q_b)
    );

    // narrow tail words are zero-extended into their slot
    assign a_rd_data[t*SLOT_W +: SLOT_W] = SLOT_W'(q_a);
    assign b_rd_data[t*SLOT_W +: SLOT_W] = SLOT_W'(q_b);
end

endmodule

`default_nettype wire

// ==== rtl/queue_lookup.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "queue_ctrl_macros.svh"

module queue_lookup (
    input  logic                                  pcie_clk,
    input  logic                                  pcie_reset_n,
    input  logic [`QUEUE_IDX_WIDTH-1:0]           rd_queue,
    input  logic                                  queue_rd_en,
    input  logic [`QUEUE_IDX_WIDTH-1:0]           wr_queue,
    input  logic                                  tail_wr_en,
    input  logic [`RB_AWIDTH-1:0]                 new_dsc_tail,
    input  logic [`RB_AWIDTH-1:0]                 new_pkt_tail,
    input  logic [1:0]                            b_head_wr_en,
    input  logic [`QUEUE_IDX_WIDTH-1:0]           b_addr,
    input  logic [2*`RB_AWIDTH-1:0]               b_head_wr_data,
    output logic [`QUEUE_IDX_WIDTH-1:0]           a_addr,
    output logic [`NB_TABLES-1:0]                 a_rd_en,
    output logic                                  a_tail_wr_en,
    output logic [2*`RB_AWIDTH-1:0]               a_tail_wr_data,
    input  logic [`NB_TABLES*`REG_SLOT_WIDTH-1:0] a_rd_data,
    output logic                                  queue_ready,
    output logic [`RB_AWIDTH-1:0]                 dsc_head,
    output logic [`RB_AWIDTH-1:0]                 dsc_tail,
    output logic [63:0]                           dsc_buf_addr,
    output logic [`RB_AWIDTH-1:0]                 pkt_head,
    output logic [`RB_AWIDTH-1:0]                 pkt_tail,
    output logic [63:0]                           pkt_buf_addr
);

logic                        tail_hit;
logic [1:0]                  head_hit;
logic [`NB_TABLES-1:0]       rd_en_r;
logic [`NB_TABLES-1:0]       rd_en_r2;
logic [2*`RB_AWIDTH-1:0]     tail_byp_r;
logic [2*`RB_AWIDTH-1:0]     tail_byp_r2;
logic [2*`RB_AWIDTH-1:0]     head_byp_r;
logic [2*`RB_AWIDTH-1:0]     head_byp_r2;
logic [`REG_SLOT_WIDTH-1:0]  a_word [`NB_TABLES];

// same-queue writes in the lookup cycle
assign tail_hit = tail_wr_en && (wr_queue == rd_queue);
assign head_hit = b_head_wr_en & {2{b_addr == rd_queue}};

assign a_tail_wr_data = {new_pkt_tail, new_dsc_tail};

//////////////////////////////
// port a control
//////////////////////////////

always_comb begin
    a_addr       = queue_rd_en ? rd_queue : wr_queue;
    a_tail_wr_en = tail_wr_en && !queue_rd_en;
    a_rd_en      = '0;
    if (queue_rd_en) begin
        a_rd_en = '1;
        // skip the ram read where a concurrent write supplies the value
        a_rd_en[queue_ctrl_pkg::dsc_tails] = !tail_hit;
        a_rd_en[queue_ctrl_pkg::pkt_tails] = !tail_hit;
        a_rd_en[queue_ctrl_pkg::dsc_heads] = !head_hit[0];
        a_rd_en[queue_ctrl_pkg::pkt_heads] = !head_hit[1];
    end
end

//////////////////////////////
// read pipeline
//////////////////////////////

always_ff @(posedge pcie_clk) begin
    if (!pcie_reset_n) begin
        rd_en_r  <= '0;
        rd_en_r2 <= '0;
    end else begin
        rd_en_r  <= a_rd_en;
        rd_en_r2 <= rd_en_r;
    end
end

// bypass values follow the ram latency
always_ff @(posedge pcie_clk) begin
    tail_byp_r  <= a_tail_wr_data;
    tail_byp_r2 <= tail_byp_r;
    head_byp_r  <= b_head_wr_data;
    head_byp_r2 <= head_byp_r;
end

always_comb begin
    for (int t = 0; t < `NB_TABLES; t++) begin
        a_word[t] = a_rd_data[t*`REG_SLOT_WIDTH +: `REG_SLOT_WIDTH];
    end
end

assign queue_ready = |rd_en_r2;

assign dsc_tail = rd_en_r2[queue_ctrl_pkg::dsc_tails]
    ? a_word[queue_ctrl_pkg::dsc_tails][`RB_AWIDTH-1:0] : tail_byp_r2[`RB_AWIDTH-1:0];
assign pkt_tail = rd_en_r2[queue_ctrl_pkg::pkt_tails]
    ? a_word[queue_ctrl_pkg::pkt_tails][`RB_AWIDTH-1:0]
    : tail_byp_r2[2*`RB_AWIDTH-1:`RB_AWIDTH];

// host head written in the lookup cycle
assign dsc_head = rd_en_r2[queue_ctrl_pkg::dsc_heads]
    ? a_word[queue_ctrl_pkg::dsc_heads][`RB_AWIDTH-1:0] : head_byp_r2[`RB_AWIDTH-1:0];
assign pkt_head = rd_en_r2[queue_ctrl_pkg::pkt_heads]
    ? a_word[queue_ctrl_pkg::pkt_heads][`RB_AWIDTH-1:0]
    : head_byp_r2[2*`RB_AWIDTH-1:`RB_AWIDTH];

assign dsc_buf_addr = {a_word[queue_ctrl_pkg::dsc_h_addrs], a_word[queue_ctrl_pkg::dsc_l_addrs]};
assign pkt_buf_addr = {a_word[queue_ctrl_pkg::pkt_h_addrs], a_word[queue_ctrl_pkg::pkt_l_addrs]};

endmodule

`default_nettype wire

// ==== rtl/pcie_reg_port.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "queue_ctrl_macros.svh"

module pcie_reg_port (
    input  logic                                  pcie_clk,
    input  logic                                  pcie_reset_n,
    input  logic [`PCIE_ADDR_WIDTH-1:0]           pcie_address_0,
    input  logic                                  pcie_write_0,
    input  logic                                  pcie_read_0,
    input  logic [`REG_LINE_WIDTH-1:0]            pcie_writedata_0,
    input  logic [`REG_BYTEEN_WIDTH-1:0]          pcie_byteenable_0,
    output logic [`NB_TABLES-1:0]                 b_wr_en,
    output logic                                  b_rd_en,
    output logic [`QUEUE_IDX_WIDTH-1:0]           b_addr,
    output logic [`NB_TABLES*`REG_SLOT_WIDTH-1:0] b_wr_data,
    input  logic [`NB_TABLES*`REG_SLOT_WIDTH-1:0] b_rd_data,
    output logic [`REG_LINE_WIDTH-1:0]            pcie_readdata_0,
    output logic                                  pcie_readdatavalid_0
);

localparam int SLOT_W     = `REG_SLOT_WIDTH;
localparam int NB_SLOTS   = `REG_LINE_WIDTH / SLOT_W;
localparam int SLOT_BYTES = `REG_BYTEEN_WIDTH / NB_SLOTS;
localparam int LINE_LSB   = $clog2(`REG_BYTEEN_WIDTH);
localparam int TBL_WIDTH  = `NB_TABLES * SLOT_W;
// tables, c2f tail, empty slot, two kmem words
localparam int PAD_WIDTH  = `REG_LINE_WIDTH - TBL_WIDTH - 4 * SLOT_W;

logic [`QUEUE_IDX_WIDTH-1:0] page_idx;
logic                        reg_region;
logic                        reg_read;
logic [NB_SLOTS-1:0]         slot_en;
logic [`NB_TABLES-1:0]       tbl_wr_sel;
queue_ctrl_pkg::port_b_op_e  port_b_op;

logic                        rd_pending;
logic [`QUEUE_IDX_WIDTH-1:0] rd_pending_addr;
logic                        rd_r;
logic                        rd_r2;

logic [SLOT_W-1:0]           c2f_tail;
logic [2*SLOT_W-1:0]         c2f_kmem_addr;

//////////////////////////////
// host decode
//////////////////////////////

assign page_idx   = pcie_address_0[`PAGE_IDX_LSB +: `QUEUE_IDX_WIDTH];
assign reg_region = pcie_address_0[`PCIE_ADDR_WIDTH-1:LINE_LSB] < `REG_REGION_LINES;
assign reg_read   = pcie_read_0 && reg_region;

// a slot counts only with all of its bytes enabled
for (genvar s = 0; s < NB_SLOTS; s++) begin : g_slot_en
    assign slot_en[s] = &pcie_byteenable_0[s*SLOT_BYTES +: SLOT_BYTES];
end

for (genvar t = 0; t < `NB_TABLES; t++) begin : g_tbl_sel
    localparam queue_ctrl_pkg::q_table_e TBL = queue_ctrl_pkg::q_table_e'(t);
    // tails are owned by the FPGA side
    assign tbl_wr_sel[t] = slot_en[t]
        && TBL != queue_ctrl_pkg::dsc_tails
        && TBL != queue_ctrl_pkg::pkt_tails;
end

//////////////////////////////
// port b arbitration
//////////////////////////////

// writes first, a pending read waits for a free cycle
always_comb begin
    if (pcie_write_0) begin
        port_b_op = queue_ctrl_pkg::port_b_write;
    end else if (rd_pending) begin
        port_b_op = queue_ctrl_pkg::port_b_read;
    end else begin
        port_b_op = queue_ctrl_pkg::port_b_idle;
    end
end

always_ff @(posedge pcie_clk) begin
    if (!pcie_reset_n) begin
        b_wr_en              <= '0;
        b_rd_en              <= 1'b0;
        rd_pending           <= 1'b0;
        rd_r                 <= 1'b0;
        rd_r2                <= 1'b0;
        pcie_readdatavalid_0 <= 1'b0;
        c2f_tail             <= '0;
        c2f_kmem_addr        <= '0;
    end else begin
        b_wr_en <= (port_b_op == queue_ctrl_pkg::port_b_write) ? tbl_wr_sel : '0;
        b_rd_en <= port_b_op == queue_ctrl_pkg::port_b_read;

        // only one read outstanding, a newer one replaces it
        if (reg_read) begin
            rd_pending <= 1'b1;
        end else if (port_b_op == queue_ctrl_pkg::port_b_read) begin
            rd_pending <= 1'b0;
        end

        // cpu to fpga registers
        if (port_b_op == queue_ctrl_pkg::port_b_write) begin
            if (slot_en[`C2F_TAIL_SLOT]) begin
                c2f_tail <= pcie_writedata_0[`C2F_TAIL_SLOT*SLOT_W +: SLOT_W];
            end
            if (slot_en[`C2F_KMEM_LO_SLOT]) begin
                c2f_kmem_addr[SLOT_W-1:0] <=
                    pcie_writedata_0[`C2F_KMEM_LO_SLOT*SLOT_W +: SLOT_W];
            end
            if (slot_en[`C2F_KMEM_HI_SLOT]) begin
                c2f_kmem_addr[2*SLOT_W-1:SLOT_W] <=
                    pcie_writedata_0[`C2F_KMEM_HI_SLOT*SLOT_W +: SLOT_W];
            end
        end

        // ram read takes two edges, then the line register
        rd_r                 <= b_rd_en;
        rd_r2                <= rd_r;
        pcie_readdatavalid_0 <= rd_r2;
    end
end

//////////////////////////////
// address and data path
//////////////////////////////

always_ff @(posedge pcie_clk) begin
    if (reg_read) begin
        rd_pending_addr <= page_idx;
    end

    if (port_b_op == queue_ctrl_pkg::port_b_write) begin
        b_addr    <= page_idx;
        b_wr_data <= pcie_writedata_0[TBL_WIDTH-1:0];
    end else if (port_b_op == queue_ctrl_pkg::port_b_read) begin
        b_addr <= rd_pending_addr;
    end

    // slot 9 has no register behind it
    pcie_readdata_0 <= {
        {PAD_WIDTH{1'b0}},
        c2f_kmem_addr,
        {SLOT_W{1'b0}},
        c2f_tail,
        b_rd_data
    };
end

endmodule

`default_nettype wire

// ==== rtl/q_table_ram.sv ====
`default_nettype none
`timescale 1ns/1ns

module q_table_ram #(
    parameter int AWIDTH = 4,
    parameter int DWIDTH = 32,
    parameter int DEPTH  = 16
) (
    input  logic              pcie_clk,
    input  logic [AWIDTH-1:0] address_a,
    input  logic [AWIDTH-1:0] address_b,
    input  logic [DWIDTH-1:0] data_a,
    input  logic [DWIDTH-1:0] data_b,
    input  logic              rden_a,
    input  logic              rden_b,
    input  logic              wren_a,
    input  logic              wren_b,
    output logic [DWIDTH-1:0] q_a,
    output logic [DWIDTH-1:0] q_b
);

logic [DWIDTH-1:0] mem [DEPTH];

// array read stage, holds between reads
logic [DWIDTH-1:0] word_a;
logic [DWIDTH-1:0] word_b;

always_ff @(posedge pcie_clk) begin
    if (wren_a) begin
        mem[address_a] <= data_a;
    end
    if (wren_b) begin
        mem[address_b] <= data_b;
    end
    // same-address read and write returns the old word
    if (rden_a) begin
        word_a <= mem[address_a];
    end
    if (rden_b) begin
        word_b <= mem[address_b];
    end
end

// output register
always_ff @(posedge pcie_clk) begin
    q_a <= word_a;
    q_b <= word_b;
end

endmodule

`default_nettype wire

// ==== rtl/queue_ctrl_pkg.sv ====
`default_nettype none

package queue_ctrl_pkg;

    // table slots, in the order they sit in the host line
    typedef enum logic [2:0] {
        dsc_tails   = 3'd0,
        dsc_heads   = 3'd1,
        dsc_l_addrs = 3'd2,
        dsc_h_addrs = 3'd3,
        pkt_tails   = 3'd4,
        pkt_heads   = 3'd5,
        pkt_l_addrs = 3'd6,
        pkt_h_addrs = 3'd7
    } q_table_e;

    // what port b is asked to do in a cycle
    typedef enum logic [1:0] {
        port_b_idle,
        port_b_write,
        port_b_read
    } port_b_op_e;

endpackage

`default_nettype wire

// ==== include/queue_ctrl_macros.svh ====
`ifndef QUEUE_CTRL_MACROS_SVH
`define QUEUE_CTRL_MACROS_SVH

// queue index and host address layout
`define QUEUE_IDX_WIDTH 4
`define PCIE_ADDR_WIDTH 18
`define PAGE_IDX_LSB 12

// host register line
`define REG_LINE_WIDTH 512
`define REG_BYTEEN_WIDTH 64
`define REG_SLOT_WIDTH 32

// 64-byte lines from address zero that map to registers
`define REG_REGION_LINES 1024

// c2f slots after the eight table words
`define C2F_TAIL_SLOT 8
`define C2F_KMEM_LO_SLOT 10
`define C2F_KMEM_HI_SLOT 11

// queue tables
`define NB_TABLES 8
`define RB_AWIDTH 16
`define RAM_DEPTH 16

`endif
